//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module rv_core

sim:
	verilator --binary --timing -f list.f --top-module tb_core -o Vtb_core
	./obj_dir/Vtb_core > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/core_pkg.sv
//////////////////////////////////////////////////
// shared widths, opcodes and decode types for the
// three-stage rv32i core. loads, stores, csr and
// fence opcodes are not listed and retire as nops
//////////////////////////////////////////////////

package core_pkg;

  localparam int XLEN       = 32;                 // data and address width
  localparam int REG_ADDR_W = 5;                  // x0..x31
  localparam int NUM_REGS   = 2**REG_ADDR_W;
  localparam int SHAMT_W    = $clog2(XLEN);       // shift amount bits
  localparam int OPC_W      = 7;

  localparam logic [XLEN-1:0] PC_RESET = '0;      // first fetch address

  // major opcodes kept by this core
  localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
  localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
  localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
  localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;
  localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;

  // funct3 for register and immediate arithmetic
  localparam logic [2:0] F3_ADD  = 3'b000;        // add, sub, addi
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;        // srl or sra by funct7 bit 5
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND
  } alu_op_t;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [OPC_W-1:0]      opcode;
  } instr_r_t;

  // i, s and b formats share this split; b takes imm bits from rd_imm_lo
  typedef struct packed {
    logic [11:0]           imm_hi;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            rd_imm_lo;
    logic [OPC_W-1:0]      opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

//--- common/pipe_if.sv
//////////////////////////////////////////////////
// stage links of the core. fetch_if valid is one
// beat per accepted instruction, flush comes back
// from execute. result_if is the execute register
//////////////////////////////////////////////////
`timescale 1ns/1ps

interface fetch_if;
  import core_pkg::*;

  logic            valid;                         // one beat per good ack
  logic [XLEN-1:0] pc;                            // address of instr
  instr_u          instr;                         // raw word, decoded two ways
  logic            flush;                         // slot after a taken branch

  modport fetch_mp (output valid, output pc, output instr, input flush);
  modport exec_mp  (input valid, input pc, input instr, output flush);
endinterface

interface result_if;
  import core_pkg::*;

  logic                  valid;                   // result register holds an instr
  logic [XLEN-1:0]       pc;
  logic [REG_ADDR_W-1:0] rd;                      // 0 when nothing is written
  logic [XLEN-1:0]       data;

  modport exec_mp   (output valid, output pc, output rd, output data);
  modport retire_mp (input valid, input pc, input rd, input data);
endinterface

//--- design/retire_stage.sv
//////////////////////////////////////////////////
// rf write straight from the result register,
// retire port one cycle later. no back-pressure
//////////////////////////////////////////////////
`timescale 1ns/1ps

module retire_stage (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  result_if.retire_mp                     result,
  output logic                            o_wr_en,
  output logic [core_pkg::REG_ADDR_W-1:0] o_wr_addr,
  output logic [core_pkg::XLEN-1:0]       o_wr_data,
  output logic                            o_retire_valid,
  output logic [core_pkg::XLEN-1:0]       o_retire_pc,
  output logic [core_pkg::REG_ADDR_W-1:0] o_retire_rd,
  output logic [core_pkg::XLEN-1:0]       o_retire_data
);

  // rf written at the end of the same cycle execute forwards from
  assign o_wr_en   = result.valid && (result.rd != '0);
  assign o_wr_addr = result.rd;
  assign o_wr_data = result.data;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_retire_valid <= 1'b0;
    end else begin
      o_retire_valid <= result.valid;             // single cycle per instr
    end
  end

  always_ff @(posedge i_clk) begin
    if (result.valid) begin
      o_retire_pc   <= result.pc;
      o_retire_rd   <= result.rd;
      o_retire_data <= result.data;
    end
  end

endmodule

//--- design/rv_core.sv
//////////////////////////////////////////////////
// rv32i top, fetch / execute / retire. integer
// ops, lui, auipc, jumps and branches only. ack to
// retire valid is 2 cycles, stalls only on ack
//////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_core (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  output logic                            o_imem_req,
  output logic [core_pkg::XLEN-1:0]       o_imem_addr,
  input  logic                            i_imem_ack,
  input  logic [core_pkg::XLEN-1:0]       i_imem_data,
  output logic                            o_retire_valid,
  output logic [core_pkg::XLEN-1:0]       o_retire_pc,
  output logic [core_pkg::REG_ADDR_W-1:0] o_retire_rd,
  output logic [core_pkg::XLEN-1:0]       o_retire_data
);
  import core_pkg::*;

  logic                  redirect;                // taken branch or jump
  logic [XLEN-1:0]       redirect_pc;
  logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
  logic [XLEN-1:0]       rs1_data, rs2_data;
  logic                  wr_en;
  logic [REG_ADDR_W-1:0] wr_addr;
  logic [XLEN-1:0]       wr_data;

  fetch_if  u_fetch_if  ();
  result_if u_result_if ();

  fetch_unit u_fetch (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .o_imem_req    (o_imem_req),
    .o_imem_addr   (o_imem_addr),
    .i_imem_ack    (i_imem_ack),
    .i_imem_data   (i_imem_data),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .fetch         (u_fetch_if.fetch_mp)
  );

  reg_file u_reg_file (
    .i_clk      (i_clk),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wr_en    (wr_en),                          // from retire_stage
    .i_wr_addr  (wr_addr),
    .i_wr_data  (wr_data)
  );

  exec_unit u_exec (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .fetch         (u_fetch_if.exec_mp),
    .o_rs1_addr    (rs1_addr),
    .o_rs2_addr    (rs2_addr),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),
    .result_fwd    (u_result_if.exec_mp),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc)
  );

  retire_stage u_retire (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .result         (u_result_if.retire_mp),
    .o_wr_en        (wr_en),
    .o_wr_addr      (wr_addr),
    .o_wr_data      (wr_data),
    .o_retire_valid (o_retire_valid),
    .o_retire_pc    (o_retire_pc),
    .o_retire_rd    (o_retire_rd),
    .o_retire_data  (o_retire_data)
  );

endmodule

//--- execute/exec_unit.sv
//////////////////////////////////////////////////
// decode, alu and branch resolve in one cycle,
// result and redirect registered. forwards only
// from the result register, rf covers the rest
//////////////////////////////////////////////////
`timescale 1ns/1ps

module exec_unit (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  fetch_if.exec_mp                        fetch,
  output logic [core_pkg::REG_ADDR_W-1:0] o_rs1_addr,
  output logic [core_pkg::REG_ADDR_W-1:0] o_rs2_addr,
  input  logic [core_pkg::XLEN-1:0]       i_rs1_data,
  input  logic [core_pkg::XLEN-1:0]       i_rs2_data,
  result_if.exec_mp                       result_fwd,
  output logic                            o_redirect,
  output logic [core_pkg::XLEN-1:0]       o_redirect_pc
);
  import core_pkg::*;

  instr_r_t              rtype;                   // r view of the word
  instr_i_t              itype;                   // i/b view of the same word
  logic [XLEN-1:0]       word;
  logic [XLEN-1:0]       imm_i, imm_b, imm_u, imm_j;
  logic [XLEN-1:0]       rs1_val, rs2_val, op_b, alu_y, pc_plus4;
  logic [XLEN-1:0]       rd_data, target;
  logic [REG_ADDR_W-1:0] rd_eff;
  alu_op_t               alu_op;
  logic                  is_op, wr_rd, taken, br_cond;
  logic                  redirect_q;
  logic [XLEN-1:0]       redirect_pc_q;

  // newest value of a source still sitting in the result register
  function automatic logic [XLEN-1:0] fwd_sel(
    input logic [REG_ADDR_W-1:0] src,
    input logic [XLEN-1:0]       rf_data,
    input logic                  res_valid,
    input logic [REG_ADDR_W-1:0] res_rd,
    input logic [XLEN-1:0]       res_data
  );
    return (res_valid && (res_rd != '0) && (res_rd == src)) ? res_data : rf_data;
  endfunction

  //////////////////////////////////////////////////
  // field extraction
  //////////////////////////////////////////////////
  assign rtype = fetch.instr.r;
  assign itype = fetch.instr.i;
  assign word  = fetch.instr;                     // u and j take bits straight off the word

  assign imm_i = {{(XLEN-12){itype.imm_hi[11]}}, itype.imm_hi};
  assign imm_b = {{(XLEN-12){itype.imm_hi[11]}}, itype.rd_imm_lo[0],
                  itype.imm_hi[10:5], itype.rd_imm_lo[4:1], 1'b0};
  assign imm_u = {word[31:12], 12'b0};
  assign imm_j = {{(XLEN-20){word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

  assign o_rs1_addr = rtype.rs1;
  assign o_rs2_addr = rtype.rs2;                  // junk for i-type, unused then
  assign rs1_val    = fwd_sel(rtype.rs1, i_rs1_data, result_fwd.valid,
                              result_fwd.rd, result_fwd.data);
  assign rs2_val    = fwd_sel(rtype.rs2, i_rs2_data, result_fwd.valid,
                              result_fwd.rd, result_fwd.data);

  assign is_op    = (rtype.opcode == OPC_OP);
  assign op_b     = is_op ? rs2_val : imm_i;
  assign pc_plus4 = fetch.pc + XLEN'(4);          // link value

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////
  always_comb begin
    case (rtype.funct3)
      F3_ADD:  alu_op = (is_op && rtype.funct7[5]) ? ALU_SUB : ALU_ADD;  // no subi
      F3_SLL:  alu_op = ALU_SLL;
      F3_SLT:  alu_op = ALU_SLT;
      F3_SLTU: alu_op = ALU_SLTU;
      F3_XOR:  alu_op = ALU_XOR;
      F3_SR:   alu_op = rtype.funct7[5] ? ALU_SRA : ALU_SRL;  // imm[10] for srai
      F3_OR:   alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_y = rs1_val + op_b;
      ALU_SUB:  alu_y = rs1_val - op_b;
      ALU_SLL:  alu_y = rs1_val << op_b[SHAMT_W-1:0];
      ALU_SLT:  alu_y = XLEN'($signed(rs1_val) < $signed(op_b));
      ALU_SLTU: alu_y = XLEN'(rs1_val < op_b);
      ALU_XOR:  alu_y = rs1_val ^ op_b;
      ALU_SRL:  alu_y = rs1_val >> op_b[SHAMT_W-1:0];
      ALU_SRA:  alu_y = $signed(rs1_val) >>> op_b[SHAMT_W-1:0];
      ALU_OR:   alu_y = rs1_val | op_b;
      default:  alu_y = rs1_val & op_b;
    endcase
  end

  //////////////////////////////////////////////////
  // branch compare and result select
  //////////////////////////////////////////////////
  always_comb begin
    case (rtype.funct3)
      F3_BEQ:  br_cond = (rs1_val == rs2_val);
      F3_BNE:  br_cond = (rs1_val != rs2_val);
      F3_BLT:  br_cond = ($signed(rs1_val) < $signed(rs2_val));
      F3_BGE:  br_cond = ($signed(rs1_val) >= $signed(rs2_val));
      F3_BLTU: br_cond = (rs1_val < rs2_val);
      F3_BGEU: br_cond = (rs1_val >= rs2_val);
      default: br_cond = 1'b0;                    // 010/011 not a branch
    endcase
  end

  always_comb begin
    wr_rd   = 1'b0;
    taken   = 1'b0;
    rd_data = alu_y;
    target  = fetch.pc + imm_b;
    case (rtype.opcode)
      OPC_OP, OPC_OP_IMM: wr_rd = 1'b1;
      OPC_LUI: begin
        wr_rd   = 1'b1;
        rd_data = imm_u;
      end
      OPC_AUIPC: begin
        wr_rd   = 1'b1;
        rd_data = fetch.pc + imm_u;
      end
      OPC_JAL: begin
        wr_rd   = 1'b1;
        rd_data = pc_plus4;
        taken   = 1'b1;
        target  = fetch.pc + imm_j;
      end
      OPC_JALR: begin
        wr_rd   = 1'b1;
        rd_data = pc_plus4;
        taken   = 1'b1;
        target  = rs1_val + imm_i;
      end
      OPC_BRANCH: taken = br_cond;
      default: wr_rd = 1'b0;                      // anything else is a nop
    endcase
  end

  assign rd_eff = wr_rd ? rtype.rd : '0;

  //////////////////////////////////////////////////
  // result register and redirect
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      result_fwd.valid <= 1'b0;
      redirect_q       <= 1'b0;
    end else begin
      result_fwd.valid <= fetch.valid;            // flushed slot arrives invalid
      redirect_q       <= fetch.valid && taken;   // one cycle pulse
    end
  end

  always_ff @(posedge i_clk) begin
    if (fetch.valid) begin
      result_fwd.pc   <= fetch.pc;
      result_fwd.rd   <= rd_eff;
      result_fwd.data <= (rd_eff != '0) ? rd_data : '0;  // nothing written reports 0
      redirect_pc_q   <= {target[XLEN-1:1], 1'b0};  // bit 0 cleared for jalr
    end
  end

  assign o_redirect    = redirect_q;
  assign o_redirect_pc = redirect_pc_q;
  assign fetch.flush   = redirect_q;              // kills the fall-through beat

endmodule

//--- execute/reg_file.sv
//////////////////////////////////////////////////
// 32 x 32 register file, two async reads and one
// clocked write. x0 reads zero, writes to it lost
//////////////////////////////////////////////////
`timescale 1ns/1ps

module reg_file (
  input  logic                            i_clk,
  input  logic [core_pkg::REG_ADDR_W-1:0] i_rs1_addr,
  input  logic [core_pkg::REG_ADDR_W-1:0] i_rs2_addr,
  output logic [core_pkg::XLEN-1:0]       o_rs1_data,
  output logic [core_pkg::XLEN-1:0]       o_rs2_data,
  input  logic                            i_wr_en,
  input  logic [core_pkg::REG_ADDR_W-1:0] i_wr_addr,
  input  logic [core_pkg::XLEN-1:0]       i_wr_data
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];               // contents undefined until written

  always_ff @(posedge i_clk) begin
    if (i_wr_en && (i_wr_addr != '0)) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  // entry 0 is never written so force the zero here
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- fetch/fetch_unit.sv
//////////////////////////////////////////////////
// pc and instruction port. req stays high once out
// of reset and addr only moves on ack. an ack for
// a fetch overtaken by a redirect is swallowed
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_unit (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  output logic                      o_imem_req,
  output logic [core_pkg::XLEN-1:0] o_imem_addr,
  input  logic                      i_imem_ack,
  input  logic [core_pkg::XLEN-1:0] i_imem_data,
  input  logic                      i_redirect,
  input  logic [core_pkg::XLEN-1:0] i_redirect_pc,
  fetch_if.fetch_mp                 fetch
);
  import core_pkg::*;

  logic            req_q;                         // request line
  logic [XLEN-1:0] pc_q;                          // address being requested
  logic            stale_q;                       // outstanding fetch is dead
  logic [XLEN-1:0] tgt_q;                         // parked redirect target
  logic            ack_ok;

  assign ack_ok      = i_imem_ack && req_q;       // ignore acks with no request
  assign o_imem_req  = req_q;
  assign o_imem_addr = pc_q;

  //////////////////////////////////////////////////
  // beat towards execute
  //////////////////////////////////////////////////
  assign fetch.valid = ack_ok && !stale_q && !fetch.flush;  // drop stale and flushed slot
  assign fetch.pc    = pc_q;                      // pc of the word being acked
  assign fetch.instr = i_imem_data;

  //////////////////////////////////////////////////
  // pc and handshake state
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      req_q   <= 1'b0;
      pc_q    <= PC_RESET;
      stale_q <= 1'b0;
    end else begin
      req_q <= 1'b1;                              // first req one cycle after release
      if (i_redirect) begin
        if (ack_ok) begin
          pc_q <= i_redirect_pc;                  // old fetch done, go straight to target
        end else begin
          stale_q <= 1'b1;                        // keep addr stable until its ack
        end
      end else if (ack_ok) begin
        if (stale_q) begin
          pc_q    <= tgt_q;                       // stale data dropped, now the target
          stale_q <= 1'b0;
        end else begin
          pc_q <= pc_q + XLEN'(4);
        end
      end
    end
  end

  // target only matters while stale_q is set
  always_ff @(posedge i_clk) begin
    if (i_redirect && !ack_ok) begin
      tgt_q <= i_redirect_pc;
    end
  end

endmodule

//--- list.f
common/core_pkg.sv
common/pipe_if.sv
fetch/fetch_unit.sv
execute/reg_file.sv
execute/exec_unit.sv
design/retire_stage.sv
design/rv_core.sv
sim/clk_gen.sv
sim/imem_model.sv
sim/tb_core.sv

//--- sim/clk_gen.sv
//////////////////////////////////////////////////
// testbench clock, 40 ns period. reset is driven
// only through hold_reset, low for 3 cycles
//////////////////////////////////////////////////
`timescale 1ns/1ps

module clk_gen (
  output logic o_clk,
  output logic o_rst_n
);
  localparam int HALF_NS = 20;                    // half of the 40 ns period

  initial begin
    o_clk = 1'b0;
    forever #HALF_NS o_clk = ~o_clk;
  end

  // assert now, release on a falling edge after 3 rising edges
  task automatic hold_reset();
    o_rst_n = 1'b0;
    repeat (3) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  endtask

endmodule

//--- sim/imem_model.sv
//////////////////////////////////////////////////
// instruction rom, 256 words, address wraps. acks
// each request after a fixed or random 0..3 delay
//////////////////////////////////////////////////
`timescale 1ns/1ps

module imem_model (
  input  logic        i_clk,
  input  logic        i_req,
  input  logic [31:0] i_addr,
  output logic        o_ack,
  output logic [31:0] o_data
);
  localparam int AW = 8;                          // word address bits

  logic [31:0] mem [2**AW];
  int          fixed_delay;
  bit          rand_delay;
  bit          pending;                           // request accepted, delay running
  int          wait_cnt;

  initial begin
    o_ack       = 1'b0;
    o_data      = '0;
    fixed_delay = 0;
    rand_delay  = 1'b0;
    pending     = 1'b0;
    wait_cnt    = 0;
  end

  task automatic set_delay(input int delay, input bit rnd);
    fixed_delay = delay;
    rand_delay  = rnd;
  endtask

  // opcode 0 is not decoded, so unused words retire as nops
  task automatic fill();
    for (int i = 0; i < 2**AW; i++) begin
      mem[i] = 32'(i) << 7;
    end
  endtask

  always @(negedge i_clk) begin
    if (!i_req) begin
      o_ack   <= 1'b0;
      pending = 1'b0;
    end else begin
      if (!pending) begin
        pending  = 1'b1;                          // new address after the last ack
        wait_cnt = rand_delay ? int'($urandom % 32'd4) : fixed_delay;
      end
      if (wait_cnt == 0) begin
        o_ack   <= 1'b1;                          // one cycle pulse with data
        o_data  <= mem[i_addr[AW+1:2]];
        pending = 1'b0;
      end else begin
        o_ack    <= 1'b0;
        wait_cnt = wait_cnt - 1;
      end
    end
  end

endmodule

//--- sim/tb_core.sv
//////////////////////////////////////////////////
// directed tests of the core. programs are built
// into the rom by helper tasks that also keep an
// isa register model for the expected retires
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_core;
  import core_pkg::*;

  localparam logic [31:0] SEED        = 32'h71a036ef;
  localparam int          RUN_TIMEOUT = 2000;     // cycles per program
  localparam int          REQ_TIMEOUT = 10;

  logic        clk, rst_n, imem_req, imem_ack, ret_valid;
  logic [31:0] imem_addr, imem_data, ret_pc, ret_data;
  logic [4:0]  ret_rd;

  logic [31:0] exp_pc[$], exp_data[$], got_pc[$], got_data[$], fwd_vals[$];
  logic [4:0]  exp_rd[$], got_rd[$];
  int          got_cyc[$], ack_cyc[$];
  logic [31:0] model_x [32];                      // expected register contents
  logic [31:0] cursor;                            // next program address
  int          cyc;
  logic        rst_seen_n;                        // reset level at the last rising edge

  clk_gen u_clkgen (.o_clk(clk), .o_rst_n(rst_n));

  imem_model u_imem (
    .i_clk (clk), .i_req (imem_req), .i_addr (imem_addr),
    .o_ack (imem_ack), .o_data (imem_data)
  );

  rv_core UUT (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .o_imem_req     (imem_req),
    .o_imem_addr    (imem_addr),
    .i_imem_ack     (imem_ack),
    .i_imem_data    (imem_data),
    .o_retire_valid (ret_valid),
    .o_retire_pc    (ret_pc),
    .o_retire_rd    (ret_rd),
    .o_retire_data  (ret_data)
  );

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic stop_run(input string why);
    $display("%s at %0t", why, $time);
    abort_run();
  endtask

  task automatic value_error(input string sig, input logic [31:0] got, input logic [31:0] exp);
    $display("error at %0t: %s is %h, expected %h", $time, sig, got, exp);
    abort_run();
  endtask

  //////////////////////////////////////////////////
  // monitors
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    rst_seen_n = rst_n;                           // reset only moves on falling edges
    if (imem_req && imem_ack) ack_cyc.push_back(cyc);  // word taken at this edge
    cyc = cyc + 1;
  end

  always @(negedge clk) begin
    if (!rst_seen_n) begin
      assert (!imem_req && !ret_valid)
        else stop_run("request or retire active during reset");
    end else if (ret_valid) begin
      got_pc.push_back(ret_pc);
      got_rd.push_back(ret_rd);
      got_data.push_back(ret_data);
      got_cyc.push_back(cyc);
    end
  end

  //////////////////////////////////////////////////
  // encoders and isa reference
  //////////////////////////////////////////////////
  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // program builders
  //////////////////////////////////////////////////
  task automatic new_program();
    exp_pc.delete();
    exp_rd.delete();
    exp_data.delete();
    u_imem.fill();
    cursor = PC_RESET;
    foreach (model_x[i]) model_x[i] = '0;
  endtask

  task automatic place(input logic [31:0] word);
    u_imem.mem[cursor[9:2]] = word;
    cursor = cursor + 32'd4;
  endtask

  // word that must never retire, addi x31, x0, -1
  task automatic skip_to(input logic [31:0] addr);
    while (cursor < addr) place(enc_i(OPC_OP_IMM, 5'd31, 3'b000, 5'd0, 12'hfff));
  endtask

  task automatic retire_op(input logic [31:0] word, input logic [4:0] rd, input logic [31:0] val);
    exp_pc.push_back(cursor);
    exp_rd.push_back(rd);
    exp_data.push_back((rd == 5'd0) ? 32'd0 : val);
    if (rd != 5'd0) model_x[rd] = val;
    place(word);
  endtask

  task automatic do_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    retire_op(enc_i(OPC_OP_IMM, rd, 3'b000, rs1, imm), rd, model_x[rs1] + sext12(imm));
  endtask

  task automatic do_rop(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
    retire_op({1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP}, rd,
              ref_alu(f3, alt, model_x[rs1], model_x[rs2]));
  endtask

  task automatic do_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    bit taken;
    taken = ref_branch(f3, model_x[rs1], model_x[rs2]);
    retire_op(enc_b(f3, rs1, rs2, 13'd8), 5'd0, 32'd0);
    if (taken) skip_to(cursor + 32'd4);
    else do_addi(5'd6, 5'd6, 12'h001);            // fall-through counter
  endtask

  task automatic build_arith();
    logic [2:0] f3s [10];
    logic       alts [10];
    f3s  = '{3'b000, 3'b000, 3'b100, 3'b110, 3'b111, 3'b010, 3'b011, 3'b001, 3'b101, 3'b101};
    alts = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    new_program();
    retire_op({20'h89abd, 5'd1, OPC_LUI}, 5'd1, {20'h89abd, 12'h000});
    do_addi(5'd1, 5'd1, 12'hdef);
    do_addi(5'd2, 5'd0, 12'hff9);
    do_addi(5'd3, 5'd0, 12'h005);                 // shift amount
    foreach (f3s[i]) do_rop(f3s[i], alts[i], 5'(i + 4), 5'd1, (i < 7) ? 5'd2 : 5'd3);
    retire_op({20'h12345, 5'd14, OPC_AUIPC}, 5'd14, cursor + {20'h12345, 12'h000});
  endtask

  task automatic build_branches();
    logic [2:0] conds [6];
    conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    new_program();
    do_addi(5'd1, 5'd0, 12'h005);
    do_addi(5'd2, 5'd0, 12'hffd);
    do_addi(5'd3, 5'd0, 12'h005);
    do_addi(5'd6, 5'd0, 12'h000);                 // counter starts from zero
    foreach (conds[i]) begin
      do_branch(conds[i], 5'd1, 5'd3);
      do_branch(conds[i], 5'd1, 5'd2);
      do_branch(conds[i], 5'd2, 5'd1);
    end
  endtask

  task automatic chain_gap(input bit spaced);
    if (spaced) begin
      do_addi(5'd0, 5'd0, 12'h000);
      do_addi(5'd0, 5'd0, 12'h000);
    end
  endtask

  task automatic build_chain(input bit spaced);
    new_program();
    do_addi(5'd1, 5'd0, 12'h005);
    chain_gap(spaced);
    do_addi(5'd2, 5'd1, 12'h003);
    chain_gap(spaced);
    do_rop(3'b000, 1'b0, 5'd3, 5'd2, 5'd1);
    chain_gap(spaced);
    do_addi(5'd3, 5'd3, 12'hfff);
    chain_gap(spaced);
    do_rop(3'b000, 1'b0, 5'd4, 5'd3, 5'd3);
  endtask

  //////////////////////////////////////////////////
  // run and check
  //////////////////////////////////////////////////
  task automatic start_core();
    u_clkgen.hold_reset();
    got_pc.delete();
    got_rd.delete();
    got_data.delete();
    got_cyc.delete();
    ack_cyc.delete();
    cyc = 0;
  endtask

  task automatic finish_program(input bit check_timing);
    int t;
    t = 0;
    while (got_pc.size() < exp_pc.size()) begin
      @(negedge clk);
      t++;
      if (t > RUN_TIMEOUT) stop_run("core stopped retiring before the program ended");
    end
    foreach (exp_pc[i]) begin
      assert (got_pc[i] == exp_pc[i]) else value_error("o_retire_pc", got_pc[i], exp_pc[i]);
      assert (got_rd[i] == exp_rd[i])
        else value_error("o_retire_rd", {27'b0, got_rd[i]}, {27'b0, exp_rd[i]});
      assert (got_data[i] == exp_data[i])
        else value_error("o_retire_data", got_data[i], exp_data[i]);
      if (check_timing) begin
        assert (got_cyc[i] == ack_cyc[i] + 2)
          else stop_run("retire did not follow its ack by 2 cycles");
      end
    end
  endtask

  task automatic test_reset();
    int t;
    new_program();
    do_addi(5'd1, 5'd0, 12'h001);
    start_core();
    assert (!imem_req) else stop_run("request raised before reset release");
    t = 0;
    while (!imem_req) begin
      @(negedge clk);
      t++;
      if (t > REQ_TIMEOUT) stop_run("no instruction request after reset");
    end
    assert (t == 1) else stop_run("first request not in the first cycle after reset");
    assert (imem_addr == PC_RESET) else value_error("o_imem_addr", imem_addr, PC_RESET);
    finish_program(1'b0);
  endtask

  task automatic test_forwarding();
    build_chain(1'b0);
    start_core();
    finish_program(1'b0);
    fwd_vals = got_data[0:4];
    build_chain(1'b1);
    start_core();
    finish_program(1'b0);
    foreach (fwd_vals[i]) begin
      assert (got_data[3 * i] == fwd_vals[i])   // every third entry is not a nop
        else value_error("o_retire_data", got_data[3 * i], fwd_vals[i]);
    end
  endtask

  task automatic test_jumps();
    new_program();
    retire_op(enc_j(5'd1, 21'd12), 5'd1, cursor + 32'd4);
    skip_to(32'd12);
    do_addi(5'd2, 5'd0, 12'h01d);
    retire_op(enc_i(OPC_JALR, 5'd3, 3'b000, 5'd2, 12'h004), 5'd3, cursor + 32'd4);
    skip_to(32'd32);                              // 29 + 4 with bit 0 cleared
    retire_op(enc_j(5'd0, 21'd8), 5'd0, 32'd0);
    skip_to(32'd40);
    do_addi(5'd0, 5'd0, 12'h037);
    do_rop(3'b000, 1'b0, 5'd5, 5'd0, 5'd1);       // x0 must still read 0
    start_core();
    finish_program(1'b0);
  endtask

  task automatic run_built(input bit check_timing);
    start_core();
    finish_program(check_timing);
  endtask

  initial begin
    void'($urandom(SEED));
    u_imem.set_delay(0, 1'b0);
    test_reset();
    build_arith();
    run_built(1'b1);
    test_forwarding();
    build_branches();
    run_built(1'b0);
    test_jumps();
    u_imem.set_delay(0, 1'b1);                    // random ack delays from here
    build_arith();
    run_built(1'b0);
    build_branches();
    run_built(1'b0);
    $display("TEST PASSED");
    $finish;
  end

endmodule
